//--- project.f
common/marble_pkg.sv
source/mmc_spi/spi_config_slave.sv
source/marble_control.sv
source/frame_pattern_gen.sv
source/gmii_to_rgmii/rgmii_tx.sv
source/led_status.sv
source/marble_top.sv
bench/marble_tb.sv

//--- Bender.yml
package:
  name: marble_eth_test

sources:
  - files:
      - common/marble_pkg.sv
      - source/mmc_spi/spi_config_slave.sv
      - source/marble_control.sv
      - source/frame_pattern_gen.sv
      - source/gmii_to_rgmii/rgmii_tx.sv
      - source/led_status.sv
      - source/marble_top.sv
  - target: simulation
    files:
      - bench/marble_tb.sv

//--- bench/marble_tb.sv
/* Directed testbench for marble_top. Drives the SPI register port, captures RGMII
   frames and checks PHY bring-up, frame content, readback and config levels */
`timescale 1ns/1ps

module marble_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	// One SPI transfer is 16 bits of 16 cycles plus framing
	localparam int SPI_CYCLES = 16 * 16 + 24;
	localparam int SPI_XFERS = 26;
	localparam int LONG_FRAME = 8 + 255 + marble_pkg::IFG_CYCLES;
	localparam int RUN_CYCLES = RESET_CYCLES + marble_pkg::PHY_RESET_CYCLES +
		marble_pkg::PHY_SETTLE_CYCLES + SPI_XFERS * SPI_CYCLES + 20 * LONG_FRAME + 1000;
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;
	localparam int FRAME_WAIT = 1000;
	// Unmapped register for readback only
	localparam marble_pkg::spi_addr_t ADDR_NONE = 8'h10;

	logic tx_clk;
	logic arst_n;
	logic clk_locked;
	logic SCLK;
	logic CSB;
	logic MOSI;
	logic MISO;
	logic PHY_RSTN;
	marble_pkg::rgmii_nibble_t RGMII_TXD_RISE;
	marble_pkg::rgmii_nibble_t RGMII_TXD_FALL;
	logic RGMII_CTL_RISE;
	logic RGMII_CTL_FALL;
	logic VCXO_EN;
	logic LD16;
	logic LD17;
	marble_pkg::led_t Pmod1;

	int mismatch_count;
	int other_count;
	int exp_frames;
	logic [31:0] rng_state;

	// Cycles since reset release on the same edges as the heartbeat divider
	logic [31:0] live_cycles;

	// Captured bytes sit in one flat queue with one entry per frame in the others
	marble_pkg::gmii_byte_t cap_data[$];
	int cap_base[$];
	int cap_len[$];
	int cap_gap[$];
	logic in_frame;
	int beats;
	int idle_beats;

	marble_top dut_i (
		.tx_clk(tx_clk), .arst_n(arst_n), .clk_locked(clk_locked),
		.SCLK(SCLK), .CSB(CSB), .MOSI(MOSI), .MISO(MISO), .PHY_RSTN(PHY_RSTN),
		.RGMII_TXD_RISE(RGMII_TXD_RISE), .RGMII_TXD_FALL(RGMII_TXD_FALL),
		.RGMII_CTL_RISE(RGMII_CTL_RISE), .RGMII_CTL_FALL(RGMII_CTL_FALL),
		.VCXO_EN(VCXO_EN), .LD16(LD16), .LD17(LD17), .Pmod1(Pmod1)
	);

	always #(CLK_PERIOD / 2) tx_clk = ~tx_clk;

	always @(posedge tx_clk) begin
		if (arst_n)
			live_cycles <= live_cycles + 32'd1;
	end

	task automatic check_byte(input marble_pkg::gmii_byte_t got,
		input marble_pkg::gmii_byte_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input marble_pkg::frame_count_t got,
		input marble_pkg::frame_count_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_leds(input marble_pkg::led_t got,
		input marble_pkg::led_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %08b expected %08b", $time, what, got, exp);
		end
	endtask

	task automatic check_length(input int got, input int exp, input string what);
		if (got != exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Preamble, then SFD, then payload byte k equal to k
	function automatic marble_pkg::gmii_byte_t expected_byte(input int k);
		if (k < marble_pkg::PREAMBLE_LEN)
			return marble_pkg::PREAMBLE_BYTE;
		else if (k == marble_pkg::PREAMBLE_LEN)
			return marble_pkg::SFD_BYTE;
		else
			return marble_pkg::gmii_byte_t'(k - marble_pkg::PREAMBLE_LEN - 1);
	endfunction

	// Rebuild bytes from both nibbles mid cycle
	always @(negedge tx_clk) begin
		if (arst_n) begin
			check_bit(RGMII_CTL_FALL, RGMII_CTL_RISE, "RGMII_CTL_FALL against RGMII_CTL_RISE");
			if (RGMII_CTL_RISE) begin
				if (!in_frame) begin
					in_frame = 1'b1;
					cap_base.push_back(cap_data.size());
					cap_gap.push_back(idle_beats);
					beats = 0;
				end
				cap_data.push_back({RGMII_TXD_FALL, RGMII_TXD_RISE});
				beats++;
			end else begin
				if (in_frame) begin
					cap_len.push_back(beats);
					in_frame = 1'b0;
					idle_beats = 0;
				end
				idle_beats++;
			end
		end
	end

	// MSB first with MOSI changing while SCLK is low and MISO sampled after each rise
	task automatic spi_transfer(input marble_pkg::spi_addr_t addr,
		input marble_pkg::gmii_byte_t data, input int nbits,
		output marble_pkg::gmii_byte_t rd);
		logic [15:0] word;
		int i;
		word = {addr, data};
		rd = '0;
		@(posedge tx_clk);
		CSB <= 1'b0;
		for (i = 0; i < nbits; i++) begin
			MOSI <= word[15 - i];
			repeat (8) @(posedge tx_clk);
			SCLK <= 1'b1;
			@(negedge tx_clk);
			if (i >= 8)
				rd = {rd[6:0], MISO};
			repeat (8) @(posedge tx_clk);
			SCLK <= 1'b0;
		end
		CSB  <= 1'b1;
		MOSI <= 1'b0;
		repeat (4) @(posedge tx_clk);
	endtask

	task automatic spi_write(input marble_pkg::spi_addr_t addr,
		input marble_pkg::gmii_byte_t data, output marble_pkg::gmii_byte_t rd);
		spi_transfer(addr, data, 16, rd);
	endtask

	task automatic wait_frames(input int n);
		int i;
		i = 0;
		while (cap_len.size() < n && i < FRAME_WAIT) begin
			@(posedge tx_clk);
			i++;
		end
		if (cap_len.size() < n) begin
			other_count++;
			$display("Frame %0d never arrived within %0d cycles at %0t", n - 1, FRAME_WAIT, $time);
		end
	endtask

	task automatic check_frame(input int idx, input marble_pkg::frame_len_t len);
		int k;
		int total;
		total = int'(len) + marble_pkg::PREAMBLE_LEN + 1;
		if (idx < cap_len.size()) begin
			check_length(cap_len[idx], total, "frame byte count");
			for (k = 0; k < total && k < cap_len[idx]; k++)
				check_byte(cap_data[cap_base[idx] + k], expected_byte(k), "frame byte");
		end
	endtask

	// Starts a frame of the given length and waits for it
	task automatic send_frame(input marble_pkg::frame_len_t len);
		marble_pkg::gmii_byte_t rd;
		int n0;
		n0 = cap_len.size();
		spi_write(marble_pkg::ADDR_FRAME_LEN, len, rd);
		spi_write(marble_pkg::ADDR_START, 8'h00, rd);
		wait_frames(n0 + 1);
		check_frame(n0, len);
		exp_frames++;
	endtask

	task automatic reset_sequence();
		int n;
		repeat (RESET_CYCLES) @(posedge tx_clk);
		arst_n <= 1'b1;
		@(negedge tx_clk);
		check_bit(PHY_RSTN, 1'b0, "PHY_RSTN after reset");
		check_byte({RGMII_TXD_FALL, RGMII_TXD_RISE}, 8'h00, "RGMII data after reset");
		check_bit(RGMII_CTL_RISE, 1'b0, "RGMII_CTL_RISE after reset");
		check_bit(RGMII_CTL_FALL, 1'b0, "RGMII_CTL_FALL after reset");
		check_bit(MISO, 1'b0, "MISO after reset");
		check_bit(VCXO_EN, 1'b1, "VCXO_EN after reset");
		check_bit(LD16, 1'b0, "LD16 after reset");
		check_bit(LD17, 1'b0, "LD17 after reset");
		// Nothing moves until the clock locks
		repeat (10) @(posedge tx_clk);
		@(negedge tx_clk);
		check_bit(PHY_RSTN, 1'b0, "PHY_RSTN without lock");
		@(posedge tx_clk);
		clk_locked <= 1'b1;
		n = 0;
		while (PHY_RSTN !== 1'b1 && n < 200) begin
			@(posedge tx_clk);
			n++;
			@(negedge tx_clk);
		end
		check_count(marble_pkg::frame_count_t'(n),
			marble_pkg::frame_count_t'(marble_pkg::PHY_RESET_CYCLES), "PHY reset cycles");
		n = 0;
		while (LD17 !== 1'b1 && n < 200) begin
			@(posedge tx_clk);
			n++;
			@(negedge tx_clk);
		end
		check_count(marble_pkg::frame_count_t'(n),
			marble_pkg::frame_count_t'(marble_pkg::PHY_SETTLE_CYCLES), "PHY settle cycles");
	endtask

	task automatic random_lengths();
		int i;
		for (i = 0; i < 5; i++) begin
			rng_state = xorshift(rng_state);
			send_frame(marble_pkg::frame_len_t'(rng_state % 64 + 1));
		end
	endtask

	task automatic count_readback();
		marble_pkg::gmii_byte_t rd;
		marble_pkg::frame_count_t exp;
		logic beat;
		exp = marble_pkg::frame_count_t'(exp_frames);
		spi_write(ADDR_NONE, 8'h00, rd);
		check_count(rd, exp, "frame count on MISO");
		@(negedge tx_clk);
		// Heartbeat follows the divider tap, link is up after settle
		beat = live_cycles[marble_pkg::HEARTBEAT_BIT];
		check_leds(Pmod1, {exp[5:0], 1'b1, beat}, "LED pattern on Pmod1");
		check_bit(LD16, beat, "heartbeat on LD16");
		check_bit(LD17, 1'b1, "link ready on LD17");
	endtask

	task automatic config_levels();
		marble_pkg::gmii_byte_t rd;
		int n0;
		int n1;
		int idx;
		spi_write(marble_pkg::ADDR_CONFIG, 8'h02, rd);
		@(negedge tx_clk);
		check_bit(VCXO_EN, 1'b0, "VCXO_EN with disable bit set");
		// Auto-repeat on with the VCXO back on
		spi_write(marble_pkg::ADDR_CONFIG, 8'h01, rd);
		@(negedge tx_clk);
		check_bit(VCXO_EN, 1'b1, "VCXO_EN with disable bit clear");
		spi_write(marble_pkg::ADDR_FRAME_LEN, 8'd10, rd);
		n0 = cap_len.size();
		spi_write(marble_pkg::ADDR_START, 8'h00, rd);
		wait_frames(n0 + 3);
		spi_write(marble_pkg::ADDR_CONFIG, 8'h00, rd);
		// Let the frame in flight drain
		repeat (60) @(posedge tx_clk);
		n1 = cap_len.size();
		repeat (200) @(posedge tx_clk);
		check_count(marble_pkg::frame_count_t'(cap_len.size()), marble_pkg::frame_count_t'(n1),
			"frames after auto-repeat cleared");
		for (idx = n0; idx < n1; idx++) begin
			check_frame(idx, 8'd10);
			if (idx > n0)
				check_bit(logic'(cap_gap[idx] >= marble_pkg::IFG_CYCLES), 1'b1,
					"idle beats between repeated frames");
		end
		exp_frames += n1 - n0;
	endtask

	task automatic busy_start();
		marble_pkg::gmii_byte_t rd;
		int n0;
		spi_write(marble_pkg::ADDR_FRAME_LEN, 8'd255, rd);
		n0 = cap_len.size();
		// Second start lands near the end of the long first frame
		spi_write(marble_pkg::ADDR_START, 8'h00, rd);
		spi_write(marble_pkg::ADDR_START, 8'h00, rd);
		wait_frames(n0 + 2);
		repeat (100) @(posedge tx_clk);
		// Frame starts are counted so a frame still in flight shows up too
		check_count(marble_pkg::frame_count_t'(cap_base.size()),
			marble_pkg::frame_count_t'(n0 + 2), "frames after start while busy");
		check_frame(n0, 8'd255);
		check_frame(n0 + 1, 8'd255);
		exp_frames += 2;
		// Ten bits only before CSB rises
		spi_transfer(marble_pkg::ADDR_START, 8'h00, 10, rd);
		repeat (100) @(posedge tx_clk);
		check_count(marble_pkg::frame_count_t'(cap_base.size()),
			marble_pkg::frame_count_t'(n0 + 2), "frames after short SPI transfer");
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: simulation still running after %0d ns", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		tx_clk = 1'b0;
		arst_n = 1'b0;
		clk_locked = 1'b0;
		SCLK = 1'b0;
		CSB = 1'b1;
		MOSI = 1'b0;
		mismatch_count = 0;
		other_count = 0;
		exp_frames = 0;
		rng_state = 32'd11;
		live_cycles = '0;
		in_frame = 1'b0;
		beats = 0;
		idle_beats = 0;

		reset_sequence();
		send_frame(8'd20);
		random_lengths();
		count_readback();
		config_levels();
		count_readback();
		busy_start();
		count_readback();

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- source/marble_top.sv
/* Marble Ethernet test build top. SPI registers drive a frame generator whose
   GMII stream leaves as RGMII rise and fall halves */
`timescale 1ns/1ps

module marble_top (
	input  logic                      tx_clk,
	input  logic                      arst_n,
	input  logic                      clk_locked,
	input  logic                      SCLK,
	input  logic                      CSB,
	input  logic                      MOSI,
	output logic                      MISO,
	output logic                      PHY_RSTN,
	output marble_pkg::rgmii_nibble_t RGMII_TXD_RISE,
	output marble_pkg::rgmii_nibble_t RGMII_TXD_FALL,
	output logic                      RGMII_CTL_RISE,
	output logic                      RGMII_CTL_FALL,
	output logic                      VCXO_EN,
	output logic                      LD16,
	output logic                      LD17,
	output marble_pkg::led_t          Pmod1
);

	// SPI write port
	logic                   wr_strobe;
	marble_pkg::spi_addr_t  wr_addr;
	marble_pkg::gmii_byte_t wr_data;

	// Control outputs
	logic                     frame_start;
	logic                     frame_done;
	logic                     link_ready;
	marble_pkg::frame_len_t   frame_len;
	marble_pkg::ext_config_t  ext_config;
	marble_pkg::frame_count_t frame_count;

	// GMII between generator and converter
	marble_pkg::gmii_byte_t gmii_txd;
	logic                   gmii_tx_en;
	logic                   gmii_tx_er;

	marble_pkg::led_t leds;

	spi_config_slave spi_i (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.sclk(SCLK), .csb(CSB), .mosi(MOSI), .miso(MISO),
		.frame_count(frame_count),
		.wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	marble_control control_i (
		.tx_clk(tx_clk), .arst_n(arst_n), .clk_locked(clk_locked),
		.wr_strobe(wr_strobe), .wr_addr(wr_addr), .wr_data(wr_data),
		.frame_done(frame_done), .phy_rstn(PHY_RSTN), .frame_start(frame_start),
		.frame_len(frame_len), .ext_config(ext_config),
		.frame_count(frame_count), .link_ready(link_ready)
	);

	frame_pattern_gen gen_i (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.frame_start(frame_start), .frame_len(frame_len),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.frame_done(frame_done)
	);

	rgmii_tx rgmii_i (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.rgmii_txd_rise(RGMII_TXD_RISE), .rgmii_txd_fall(RGMII_TXD_FALL),
		.rgmii_ctl_rise(RGMII_CTL_RISE), .rgmii_ctl_fall(RGMII_CTL_FALL)
	);

	led_status led_i (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.link_ready(link_ready), .frame_count(frame_count), .leds(leds)
	);

	assign Pmod1 = leds;
	assign LD16  = leds[0];
	assign LD17  = leds[1];

	// Software can switch the 20 MHz VCXO off
	assign VCXO_EN = ~ext_config[1];

endmodule

//--- source/led_status.sv
/* Board LED pattern: heartbeat on bit 0, link ready on bit 1,
   low frame count bits above */
`timescale 1ns/1ps

module led_status (
	input  logic                     tx_clk,
	input  logic                     arst_n,
	input  logic                     link_ready,
	input  marble_pkg::frame_count_t frame_count,
	output marble_pkg::led_t         leds
);

	// Free-running divider, top bit is the heartbeat
	logic [marble_pkg::HEARTBEAT_BIT:0] div_cnt;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// Six count bits, link, heartbeat
	assign leds = {frame_count[5:0], link_ready, div_cnt[marble_pkg::HEARTBEAT_BIT]};

endmodule

//--- source/gmii_to_rgmii/rgmii_tx.sv
/* GMII to RGMII transmit split: low nibble for the rising edge, high nibble
   for the falling edge, with the RGMII control encoding per edge */
`timescale 1ns/1ps

module rgmii_tx (
	input  logic                      tx_clk,
	input  logic                      arst_n,
	input  marble_pkg::gmii_byte_t    gmii_txd,
	input  logic                      gmii_tx_en,
	input  logic                      gmii_tx_er,
	output marble_pkg::rgmii_nibble_t rgmii_txd_rise,
	output marble_pkg::rgmii_nibble_t rgmii_txd_fall,
	output logic                      rgmii_ctl_rise,
	output logic                      rgmii_ctl_fall
);

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rgmii_txd_rise <= '0;
			rgmii_txd_fall <= '0;
			rgmii_ctl_rise <= 1'b0;
			rgmii_ctl_fall <= 1'b0;
		end else begin
			// Bits 3:0 go out first
			rgmii_txd_rise <= gmii_txd[3:0];
			rgmii_txd_fall <= gmii_txd[7:4];
			// TX_CTL carries enable on the rise
			rgmii_ctl_rise <= gmii_tx_en;
			// and enable XOR error on the fall
			rgmii_ctl_fall <= gmii_tx_en ^ gmii_tx_er;
		end
	end

endmodule

//--- source/frame_pattern_gen.sv
/* GMII test frame source. A start pulse launches preamble, SFD and an
   incrementing payload of the programmed length, one byte per tx_clk */
`timescale 1ns/1ps

module frame_pattern_gen (
	input  logic                   tx_clk,
	input  logic                   arst_n,
	input  logic                   frame_start,
	input  marble_pkg::frame_len_t frame_len,
	output marble_pkg::gmii_byte_t gmii_txd,
	output logic                   gmii_tx_en,
	output logic                   gmii_tx_er,
	output logic                   frame_done
);

	// Position of the byte to be emitted next
	// Up to 8 header bytes plus 255 payload bytes
	logic [8:0] pos;

	// Length latched for the whole frame
	marble_pkg::frame_len_t len_q;

	// Position of the last payload byte
	logic [8:0] last_pos;

	// Header takes positions 0 to 7 and the SFD sits at PREAMBLE_LEN
	assign last_pos = 9'(marble_pkg::PREAMBLE_LEN) + {1'b0, len_q};

	always_ff @(posedge tx_clk) begin
		if (frame_start)
			len_q <= frame_len;
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			pos        <= '0;
			gmii_txd   <= '0;
			gmii_tx_en <= 1'b0;
			gmii_tx_er <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			// No error signalling in the test pattern
			gmii_tx_er <= 1'b0;
			if (frame_start) begin
				// First preamble byte goes out right away
				pos        <= 9'd1;
				gmii_txd   <= marble_pkg::PREAMBLE_BYTE;
				gmii_tx_en <= 1'b1;
				frame_done <= 1'b0;
			end else if (gmii_tx_en && !frame_done) begin
				pos <= pos + 9'd1;
				if (pos < 9'(marble_pkg::PREAMBLE_LEN)) begin
					gmii_txd <= marble_pkg::PREAMBLE_BYTE;
				end else if (pos == 9'(marble_pkg::PREAMBLE_LEN)) begin
					gmii_txd <= marble_pkg::SFD_BYTE;
				end else begin
					// Payload byte k carries k
					gmii_txd <= 8'(pos - 9'(marble_pkg::PREAMBLE_LEN + 1));
					// A zero length still sends one payload byte
					if (pos >= last_pos)
						frame_done <= 1'b1;
				end
			end else begin
				// Frame over or never started
				pos        <= '0;
				gmii_txd   <= '0;
				gmii_tx_en <= 1'b0;
				frame_done <= 1'b0;
			end
		end
	end

endmodule

//--- source/marble_control.sv
/* Board sequencer: PHY reset after clock lock, frame launch FSM, and the
   software registers written over SPI */
`timescale 1ns/1ps

module marble_control (
	input  logic                     tx_clk,
	input  logic                     arst_n,
	input  logic                     clk_locked,
	input  logic                     wr_strobe,
	input  marble_pkg::spi_addr_t    wr_addr,
	input  marble_pkg::gmii_byte_t   wr_data,
	input  logic                     frame_done,
	output logic                     phy_rstn,
	output logic                     frame_start,
	output marble_pkg::frame_len_t   frame_len,
	output marble_pkg::ext_config_t  ext_config,
	output marble_pkg::frame_count_t frame_count,
	output logic                     link_ready
);

	marble_pkg::ctrl_state_t state;

	// Shared by reset, settle and gap timing, 64 is the longest count
	logic [6:0] delay_cnt;

	logic start_wr;
	logic start_pending;
	logic auto_repeat;
	logic launch_idle;
	logic launch_gap;

	assign start_wr    = wr_strobe && (wr_addr == marble_pkg::ADDR_START);
	assign auto_repeat = ext_config[0];

	// A start either arrives now or was held back while busy
	assign launch_idle = (state == marble_pkg::idle) && (start_wr || start_pending);
	assign launch_gap  = (state == marble_pkg::gap) && auto_repeat &&
		(delay_cnt == 7'(marble_pkg::IFG_CYCLES - 1));

	assign link_ready = (state == marble_pkg::idle) || (state == marble_pkg::sending) ||
		(state == marble_pkg::gap);

	// Register writes
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			ext_config <= marble_pkg::CONFIG_DEFAULT;
			frame_len  <= marble_pkg::FRAME_LEN_DEFAULT;
		end else if (wr_strobe) begin
			if (wr_addr == marble_pkg::ADDR_CONFIG)
				ext_config <= wr_data[3:0];
			if (wr_addr == marble_pkg::ADDR_FRAME_LEN)
				frame_len <= wr_data;
		end
	end

	// Pending start and frame counter
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			start_pending <= 1'b0;
			frame_count   <= '0;
		end else begin
			if (launch_idle)
				start_pending <= 1'b0;
			else if (start_wr)
				start_pending <= 1'b1;
			if (frame_done)
				frame_count <= frame_count + 8'd1;
		end
	end

	// Main sequencer
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= marble_pkg::phy_reset;
			delay_cnt   <= '0;
			phy_rstn    <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= launch_idle || launch_gap;
			case (state)
				marble_pkg::phy_reset: begin
					// Hold the PHY in reset until the clock has been locked long enough
					if (clk_locked) begin
						if (delay_cnt == 7'(marble_pkg::PHY_RESET_CYCLES - 1)) begin
							delay_cnt <= '0;
							phy_rstn  <= 1'b1;
							state     <= marble_pkg::phy_settle;
						end else begin
							delay_cnt <= delay_cnt + 7'd1;
						end
					end
				end
				marble_pkg::phy_settle: begin
					if (delay_cnt == 7'(marble_pkg::PHY_SETTLE_CYCLES - 1)) begin
						delay_cnt <= '0;
						state     <= marble_pkg::idle;
					end else begin
						delay_cnt <= delay_cnt + 7'd1;
					end
				end
				marble_pkg::idle: begin
					if (launch_idle)
						state <= marble_pkg::sending;
				end
				marble_pkg::sending: begin
					if (frame_done) begin
						delay_cnt <= '0;
						state     <= auto_repeat ? marble_pkg::gap : marble_pkg::idle;
					end
				end
				marble_pkg::gap: begin
					// Dropping auto-repeat mid gap ends the stream
					if (!auto_repeat)
						state <= marble_pkg::idle;
					else if (launch_gap)
						state <= marble_pkg::sending;
					else
						delay_cnt <= delay_cnt + 7'd1;
				end
				default: state <= marble_pkg::phy_reset;
			endcase
		end
	end

endmodule

//--- source/mmc_spi/spi_config_slave.sv
/* SPI write port from the microcontroller, oversampled in tx_clk.
   Takes 16-bit address/data frames and shifts the frame count back on MISO */
`timescale 1ns/1ps

module spi_config_slave (
	input  logic                     tx_clk,
	input  logic                     arst_n,
	input  logic                     sclk,
	input  logic                     csb,
	input  logic                     mosi,
	input  marble_pkg::frame_count_t frame_count,
	output logic                     miso,
	output logic                     wr_strobe,
	output marble_pkg::spi_addr_t    wr_addr,
	output marble_pkg::gmii_byte_t   wr_data
);

	// Two-flop synchronizers plus one more SCLK stage for edge detect
	logic [1:0] sclk_sync;
	logic [1:0] csb_sync;
	logic [1:0] mosi_sync;
	logic       sclk_d;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       cs_active;

	// Received bits with the first one ending up on top
	logic [14:0] shift_in;
	logic [4:0]  bit_cnt;

	// Readback shifter
	marble_pkg::frame_count_t miso_sr;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			sclk_sync <= 2'b00;
			// Chip select idles high
			csb_sync  <= 2'b11;
			mosi_sync <= 2'b00;
			sclk_d    <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			csb_sync  <= {csb_sync[0], csb};
			mosi_sync <= {mosi_sync[0], mosi};
			sclk_d    <= sclk_sync[1];
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_d;
	assign sclk_fall = ~sclk_sync[1] & sclk_d;
	assign cs_active = ~csb_sync[1];

	// Bit counter and write strobe
	// Counter parks at 16 until CSB goes high so extra bits cannot strobe again
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt   <= 5'd0;
			wr_strobe <= 1'b0;
		end else begin
			wr_strobe <= 1'b0;
			if (!cs_active) begin
				bit_cnt <= 5'd0;
			end else if (sclk_rise && bit_cnt != 5'd16) begin
				bit_cnt <= bit_cnt + 5'd1;
				// Last bit of the frame
				if (bit_cnt == 5'd15)
					wr_strobe <= 1'b1;
			end
		end
	end

	// Data path shifts in MSB first on each rising edge
	always_ff @(posedge tx_clk) begin
		if (cs_active && sclk_rise && bit_cnt != 5'd16) begin
			shift_in <= {shift_in[13:0], mosi_sync[1]};
			if (bit_cnt == 5'd15) begin
				wr_addr <= shift_in[14:7];
				wr_data <= {shift_in[6:0], mosi_sync[1]};
			end
		end
	end

	// MISO changes on falling edges so the master samples it on the next rise
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			miso    <= 1'b0;
			miso_sr <= '0;
		end else if (!cs_active) begin
			miso <= 1'b0;
		end else if (sclk_fall) begin
			if (bit_cnt == 5'd8) begin
				// Address done so the count goes out during the data byte
				miso    <= frame_count[7];
				miso_sr <= {frame_count[6:0], 1'b0};
			end else if (bit_cnt > 5'd8 && bit_cnt < 5'd16) begin
				miso    <= miso_sr[7];
				miso_sr <= {miso_sr[6:0], 1'b0};
			end else begin
				miso <= 1'b0;
			end
		end
	end

endmodule

//--- common/marble_pkg.sv
/* Shared widths, control FSM states, register map and timing constants for the Marble
   Ethernet test path, referenced by scoped name from every RTL block */
package marble_pkg;

	// One GMII byte, one RGMII half-word
	typedef logic [7:0] gmii_byte_t;
	typedef logic [3:0] rgmii_nibble_t;

	// Bit 0 auto-repeat, bit 1 VCXO disable, bits 3:2 spare
	typedef logic [3:0] ext_config_t;

	// Payload length in bytes
	typedef logic [7:0] frame_len_t;

	// Completed frames, wraps at 256
	typedef logic [7:0] frame_count_t;

	typedef logic [7:0] led_t;
	typedef logic [7:0] spi_addr_t;

	// Control sequencer states
	typedef enum logic [2:0] {
		phy_reset,
		phy_settle,
		idle,
		sending,
		gap
	} ctrl_state_t;

	// PHY bring-up, in tx_clk cycles
	localparam int PHY_RESET_CYCLES = 64;
	localparam int PHY_SETTLE_CYCLES = 32;

	// Idle beats between auto-repeated frames
	localparam int IFG_CYCLES = 12;

	// Frame framing bytes
	localparam int PREAMBLE_LEN = 7;
	localparam gmii_byte_t PREAMBLE_BYTE = 8'h55;
	localparam gmii_byte_t SFD_BYTE = 8'hD5;

	// SPI register map
	localparam spi_addr_t ADDR_CONFIG = 8'd0;
	localparam spi_addr_t ADDR_FRAME_LEN = 8'd1;
	localparam spi_addr_t ADDR_START = 8'd2;

	// Values after reset
	localparam ext_config_t CONFIG_DEFAULT = 4'd0;
	localparam frame_len_t FRAME_LEN_DEFAULT = 8'd16;

	// Divider tap for the heartbeat LED
	localparam int HEARTBEAT_BIT = 23;

endpackage
